// File: include/aes_config.svh
// Width and latency macros for the AES table lookup block.
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Width of one byte of the AES state.
`define AES_BYTE_W 8

// Width of one state column.
`define AES_WORD_W 32

// Number of bytes in a column word.
`define AES_WORD_BYTES 4

// Clock cycles from a sampled input to its registered result.
`define AES_LOOKUP_LAT 1

`endif

// File: source/aes_types_pkg.sv
// Byte, column word and lane array types for the AES lookup block.
`include "aes_config.svh"

package aes_types_pkg;

    // One byte of the AES state.
    typedef logic [`AES_BYTE_W-1:0] aes_byte_t;

    // A column word built from bytes.
    // Index 0 is the most significant byte, so word[0] is b0 of the column.
    typedef aes_byte_t [0:`AES_WORD_BYTES-1] aes_word_t;

    // One word per byte lane, indexed by lane number.
    typedef aes_word_t aes_lane_words_t [`AES_WORD_BYTES];

endpackage

// File: source/aes_sbox_pkg.sv
// Forward S-box table, GF(2^8) doubling and byte rotation of words.
`include "aes_config.svh"

package aes_sbox_pkg;

    import aes_types_pkg::*;

    // Forward S-box, indexed by the input byte.
    localparam aes_byte_t aes_sbox_table [2**`AES_BYTE_W] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Reduction term of the AES field polynomial x^8 + x^4 + x^3 + x + 1.
    localparam aes_byte_t AES_GF_POLY = 8'h1b;

    // Multiply a byte by x in GF(2^8).
    function automatic aes_byte_t gf_double(input aes_byte_t b);
        aes_byte_t shifted;
        shifted = {b[`AES_BYTE_W-2:0], 1'b0};
        if (b[`AES_BYTE_W-1]) begin
            shifted = shifted ^ AES_GF_POLY;
        end
        return shifted;
    endfunction

    // Rotate a word right by a whole number of bytes.
    // The byte count wraps modulo the number of bytes in a word.
    function automatic aes_word_t rotr_bytes(input aes_word_t w, input int unsigned n);
        int unsigned sh;
        aes_word_t   lo;
        aes_word_t   hi;
        sh = (n % `AES_WORD_BYTES) * `AES_BYTE_W;
        lo = w >> sh;
        // A left shift by the full word width yields zero, so n = 0 gives w back.
        hi = w << (`AES_WORD_W - sh);
        return lo | hi;
    endfunction

endpackage

// File: source/aes_sbox.sv
// Registered single-byte S-box lookup.
`timescale 1ns/1ps

module aes_sbox
    import aes_types_pkg::*;
    import aes_sbox_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  aes_byte_t in_byte,
    output aes_byte_t out_byte
);

    // The table read is registered, which gives the one-cycle lookup latency.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_byte <= '0;
        end else begin
            out_byte <= aes_sbox_table[in_byte];
        end
    end

endmodule

// File: source/aes_tbox.sv
// One T-table lane built from a registered S-box and field doubling.
`timescale 1ns/1ps

module aes_tbox
    import aes_types_pkg::*;
    import aes_sbox_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  aes_byte_t in_byte,
    output aes_word_t t_word
);

    aes_byte_t s_byte;
    aes_byte_t s_dbl;
    aes_byte_t s_tpl;

    aes_sbox sbox (
        .clk      (clk),
        .rst      (rst),
        .in_byte  (in_byte),
        .out_byte (s_byte)
    );

    // 2*S and 3*S are formed after the register, so the lane keeps one cycle of latency.
    // A cleared register gives zero here as well.
    assign s_dbl = gf_double(s_byte);
    assign s_tpl = s_byte ^ s_dbl;

    // The unrotated T word holds S, S, 3*S and 2*S from the most significant byte down.
    assign t_word = {s_byte, s_byte, s_tpl, s_dbl};

endmodule

// File: source/aes_table_lookup.sv
// Top level with four T-table lanes, their fixed rotations and a four-byte sub-word path.
`timescale 1ns/1ps

module aes_table_lookup
    import aes_types_pkg::*;
    import aes_sbox_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  aes_word_t state,
    input  aes_word_t sub_in,
    output aes_word_t p0,
    output aes_word_t p1,
    output aes_word_t p2,
    output aes_word_t p3,
    output aes_word_t sub_out
);

    aes_lane_words_t t_words;

    // Byte k of state feeds lane k, with state[0] the most significant byte.
    aes_tbox lane0 (
        .clk     (clk),
        .rst     (rst),
        .in_byte (state[0]),
        .t_word  (t_words[0])
    );

    aes_tbox lane1 (
        .clk     (clk),
        .rst     (rst),
        .in_byte (state[1]),
        .t_word  (t_words[1])
    );

    aes_tbox lane2 (
        .clk     (clk),
        .rst     (rst),
        .in_byte (state[2]),
        .t_word  (t_words[2])
    );

    aes_tbox lane3 (
        .clk     (clk),
        .rst     (rst),
        .in_byte (state[3]),
        .t_word  (t_words[3])
    );

    // Lane k is rotated right by k + 1 bytes modulo four, which places each lane's
    // MixColumns coefficients in column order.
    assign p0 = rotr_bytes(t_words[0], 1);
    assign p1 = rotr_bytes(t_words[1], 2);
    assign p2 = rotr_bytes(t_words[2], 3);
    assign p3 = t_words[3];

    // Sub-word path, byte for byte.
    aes_sbox sub0 (
        .clk      (clk),
        .rst      (rst),
        .in_byte  (sub_in[0]),
        .out_byte (sub_out[0])
    );

    aes_sbox sub1 (
        .clk      (clk),
        .rst      (rst),
        .in_byte  (sub_in[1]),
        .out_byte (sub_out[1])
    );

    aes_sbox sub2 (
        .clk      (clk),
        .rst      (rst),
        .in_byte  (sub_in[2]),
        .out_byte (sub_out[2])
    );

    aes_sbox sub3 (
        .clk      (clk),
        .rst      (rst),
        .in_byte  (sub_in[3]),
        .out_byte (sub_out[3])
    );

endmodule

// File: include/aes_tb_model.svh
// Reference model functions for field multiply, field inverse, S-box affine map and output words.
`ifndef AES_TB_MODEL_SVH
`define AES_TB_MODEL_SVH

// The including scope must import aes_types_pkg.

// Multiply two elements of GF(2^8) modulo x^8 + x^4 + x^3 + x + 1.
function automatic aes_byte_t field_mul(input aes_byte_t a, input aes_byte_t b);
    aes_byte_t acc;
    aes_byte_t x;
    int        i;
    acc = '0;
    x   = a;
    for (i = 0; i < 8; i++) begin
        if (b[i]) begin
            acc = acc ^ x;
        end
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return acc;
endfunction

// The field inverse a^254 is the product of the squares a^2 to a^128.
// Zero maps to zero, as the S-box definition requires.
function automatic aes_byte_t field_inv(input aes_byte_t a);
    aes_byte_t sq;
    aes_byte_t acc;
    int        k;
    sq  = a;
    acc = 8'h01;
    for (k = 1; k < 8; k++) begin
        sq  = field_mul(sq, sq);
        acc = field_mul(acc, sq);
    end
    return acc;
endfunction

// The forward S-box affine map XORs the byte with its left rotations by 1 to 4 and with 0x63.
function automatic aes_byte_t sbox_affine(input aes_byte_t b);
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
             ^ {b[3:0], b[7:4]} ^ 8'h63;
endfunction

function automatic aes_byte_t sbox_byte(input aes_byte_t b);
    return sbox_affine(field_inv(b));
endfunction

// Expected output word of lane 0 to 3 for the state byte of that lane.
function automatic aes_word_t expected_lane_word(input int lane, input aes_byte_t b);
    aes_byte_t s;
    aes_byte_t s2;
    aes_byte_t s3;
    aes_word_t w;
    s  = sbox_byte(b);
    s2 = field_mul(s, 8'h02);
    s3 = field_mul(s, 8'h03);
    case (lane)
        0:       w = {s2, s, s, s3};
        1:       w = {s3, s2, s, s};
        2:       w = {s, s3, s2, s};
        default: w = {s, s, s3, s2};
    endcase
    return w;
endfunction

function automatic aes_word_t expected_sub_word(input aes_word_t w);
    return {sbox_byte(w[0]), sbox_byte(w[1]), sbox_byte(w[2]), sbox_byte(w[3])};
endfunction

`endif

// File: tests/aes_table_lookup_tb.sv
// Testbench for the AES table lookup block with clock, reset, stimulus and output assertions.
`timescale 1ns/1ps
`include "aes_config.svh"

module aes_table_lookup_tb
    import aes_types_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 4;
    localparam int STREAM_CYCLES   = 200;
    localparam int RUN_LIMIT_NS    = 100000;

    logic      clk;
    logic      rst;
    aes_word_t state;
    aes_word_t sub_in;
    aes_word_t p0;
    aes_word_t p1;
    aes_word_t p2;
    aes_word_t p3;
    aes_word_t sub_out;

    // Expected outputs for the inputs sampled at the last rising edge.
    aes_word_t exp_p0;
    aes_word_t exp_p1;
    aes_word_t exp_p2;
    aes_word_t exp_p3;
    aes_word_t exp_sub;

    integer seed;
    string  test_name;

    `include "aes_tb_model.svh"

    aes_table_lookup DUT (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .sub_in  (sub_in),
        .p0      (p0),
        .p1      (p1),
        .p2      (p2),
        .p3      (p3),
        .sub_out (sub_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // One-deep history. Reset clears it, as every S-box register reads zero in reset.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_p0  <= '0;
            exp_p1  <= '0;
            exp_p2  <= '0;
            exp_p3  <= '0;
            exp_sub <= '0;
        end else begin
            exp_p0  <= expected_lane_word(0, state[0]);
            exp_p1  <= expected_lane_word(1, state[1]);
            exp_p2  <= expected_lane_word(2, state[2]);
            exp_p3  <= expected_lane_word(3, state[3]);
            exp_sub <= expected_sub_word(sub_in);
        end
    end

    assert property (@(posedge clk) p0 == exp_p0)
        else stop_on_error($sformatf("Error: %s p0 expected %h actual %h",
                                     test_name, $sampled(exp_p0), $sampled(p0)));

    assert property (@(posedge clk) p1 == exp_p1)
        else stop_on_error($sformatf("Error: %s p1 expected %h actual %h",
                                     test_name, $sampled(exp_p1), $sampled(p1)));

    assert property (@(posedge clk) p2 == exp_p2)
        else stop_on_error($sformatf("Error: %s p2 expected %h actual %h",
                                     test_name, $sampled(exp_p2), $sampled(p2)));

    assert property (@(posedge clk) p3 == exp_p3)
        else stop_on_error($sformatf("Error: %s p3 expected %h actual %h",
                                     test_name, $sampled(exp_p3), $sampled(p3)));

    assert property (@(posedge clk) sub_out == exp_sub)
        else stop_on_error($sformatf("Error: %s sub_out expected %h actual %h",
                                     test_name, $sampled(exp_sub), $sampled(sub_out)));

    task automatic drive_inputs(input aes_word_t next_state, input aes_word_t next_sub);
        @(posedge clk);
        #(DRIVE_DELAY);
        state  = next_state;
        sub_in = next_sub;
    endtask

    task automatic check_word(input string port, input aes_word_t expected,
                              input aes_word_t actual);
        assert (actual == expected)
            else stop_on_error($sformatf("Error: %s %s expected %h actual %h",
                                         test_name, port, expected, actual));
    endtask

    task automatic check_outputs_zero();
        check_word("p0", '0, p0);
        check_word("p1", '0, p1);
        check_word("p2", '0, p2);
        check_word("p3", '0, p3);
        check_word("sub_out", '0, sub_out);
    endtask

    task automatic wait_for_sub_out(input aes_word_t value, input int limit);
        int n;
        n = 0;
        while (sub_out != value && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (sub_out != value) begin
            stop_on_error($sformatf("Timeout in %s: sub_out did not reach %h within %0d cycles",
                                    test_name, value, limit));
        end
    endtask

    // Raises reset while random traffic continues, then releases it with a fresh input.
    task automatic reset_midstream();
        @(posedge clk);
        #(DRIVE_DELAY);
        rst    = 1'b1;
        state  = $random(seed);
        sub_in = $random(seed);
        #1;
        check_outputs_zero();
        drive_inputs($random(seed), $random(seed));
        #1;
        check_outputs_zero();
        @(posedge clk);
        #(DRIVE_DELAY);
        rst    = 1'b0;
        state  = $random(seed);
        sub_in = $random(seed);
        #1;
        check_outputs_zero();
    endtask

    initial begin
        int        i;
        int        v;
        aes_byte_t b;
        rst         = 1'b0;
        state       = '0;
        sub_in      = '0;
        seed        = 32'hd11d_1187;
        test_name   = "reset";

        // A clean rising edge on rst clears every register before the first clock edge.
        #(DRIVE_DELAY);
        rst = 1'b1;

        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            check_outputs_zero();
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        #1;
        check_outputs_zero();

        test_name = "known_vector";
        drive_inputs('0, '0);
        wait_for_sub_out(32'h63636363, `AES_LOOKUP_LAT + 2);
        check_word("p0", 32'hc66363a5, p0);
        check_word("p1", 32'ha5c66363, p1);
        check_word("p2", 32'h63a5c663, p2);
        check_word("p3", 32'h6363a5c6, p3);

        // Each lane sees every byte value once, with a different pattern per lane.
        test_name = "exhaustive";
        for (v = 0; v < 256; v++) begin
            b = v[7:0];
            drive_inputs({b, b ^ 8'h55, b ^ 8'haa, ~b}, {~b, b, b ^ 8'h3c, b ^ 8'hc3});
        end

        test_name = "streaming";
        for (i = 0; i < STREAM_CYCLES; i++) begin
            drive_inputs($random(seed), $random(seed));
        end

        test_name = "reset_midstream";
        reset_midstream();

        test_name = "stream_after_reset";
        for (i = 0; i < STREAM_CYCLES; i++) begin
            drive_inputs($random(seed), $random(seed));
        end

        drive_inputs('0, '0);
        for (i = 0; i < `AES_LOOKUP_LAT + 1; i++) begin
            @(posedge clk);
        end
        #1;
        $display("test passed");
        $finish;
    end

    initial begin
        #(RUN_LIMIT_NS);
        stop_on_error("Timeout: the run did not reach its end within the time limit");
    end

endmodule

// File: aes_table_lookup.f
+incdir+include
source/aes_types_pkg.sv
source/aes_sbox_pkg.sv
source/aes_sbox.sv
source/aes_tbox.sv
source/aes_table_lookup.sv
tests/aes_table_lookup_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the AES table lookup testbench with Verilator and runs it.
# The script returns the simulator's exit status, which is non-zero on any error.

cd "$(dirname "$0")" || exit 1

TOP=aes_table_lookup_tb
FILELIST=aes_table_lookup.f
OBJ_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

if [ ! -f "$FILELIST" ]; then
    echo "file list $FILELIST is missing"
    exit 1
fi

rm -rf "$OBJ_DIR"
status=$?
if [ $status -ne 0 ]; then
    echo "could not remove the old build directory"
    exit $status
fi

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    --Mdir "$OBJ_DIR" \
    -f "$FILELIST"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build ended with status $status"
    exit $status
fi

"./$OBJ_DIR/V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

echo "Simulation ended with status 0"
exit 0
